/* dv/regRename_vectors.txt */
# test rdy flush iValid rs1 rs2 rd op pc imm pred aValid aRd aTag cValid cRd cData cTag
# then expected: valid rs1Data rs2Data rs1Tag rs2Tag rs1Rdy rs2Rdy rd op pc imm pred (hex)
1 1 0 0 0 0 0 0 0 0 0 0 0 0 1 5 a5a5 0 0 0 0 0 0 0 0 0 0 0 0 0
1 1 0 1 5 0 6 1 100 0 0 0 0 0 1 0 ffff 0 1 a5a5 0 0 0 1 1 6 1 100 0 0
1 1 0 1 0 5 7 b 104 10 0 0 0 0 0 0 0 0 1 0 a5a5 0 0 1 1 7 b 104 10 0
1 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
2 1 0 0 0 0 0 0 0 0 0 1 8 3 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
2 1 0 1 8 5 9 1 108 0 1 0 0 0 1 8 1234 3 1 0 a5a5 3 0 0 1 9 1 108 0 1
2 1 0 1 8 8 a 2 10c 0 0 0 0 0 0 0 0 0 1 1234 1234 0 0 1 1 a 2 10c 0 0
2 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
3 1 0 0 0 0 0 0 0 0 0 1 c 5 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
3 1 0 0 0 0 0 0 0 0 0 0 0 0 1 c beef 6 0 0 0 0 0 0 0 0 0 0 0 0
3 1 0 1 c 0 d 16 110 8 0 0 0 0 1 5 9999 2 1 0 0 5 0 0 1 d 16 110 8 0
3 1 0 1 5 c e 1 114 0 0 0 0 0 0 0 0 0 1 a5a5 0 0 5 1 0 e 1 114 0 0
3 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
4 1 0 1 5 8 0 1b 118 4 0 1 5 7 0 0 0 0 1 a5a5 1234 0 0 1 1 0 1b 118 4 0
4 1 0 1 5 5 0 1c 11c 20 1 1 8 9 0 0 0 0 1 a5a5 a5a5 0 0 1 1 0 1c 11c 20 1
4 1 0 1 5 8 f 1 120 0 0 1 10 4 0 0 0 0 1 a5a5 1234 0 0 1 1 f 1 120 0 0
4 1 0 1 10 0 11 1 124 0 0 0 0 0 0 0 0 0 1 0 0 4 0 0 1 11 1 124 0 0
4 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
5 1 1 1 c 10 12 1 128 0 0 1 14 2 1 c cafe 1 0 0 0 0 0 0 0 0 0 0 0 0
5 1 0 1 c 10 13 1 12c 0 0 0 0 0 0 0 0 0 1 cafe 0 0 0 1 1 13 1 12c 0 0
5 1 0 1 14 0 15 1 130 0 0 0 0 0 0 0 0 0 1 0 0 0 0 1 1 15 1 130 0 0
5 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
6 1 0 1 5 8 16 1 134 0 0 0 0 0 0 0 0 0 1 a5a5 1234 0 0 1 1 16 1 134 0 0
6 0 0 1 8 0 17 1 138 0 0 1 8 6 1 5 7777 0 1 a5a5 1234 0 0 1 1 16 1 134 0 0
6 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 a5a5 1234 0 0 1 1 16 1 134 0 0
6 1 0 1 5 8 18 1 13c 0 0 0 0 0 0 0 0 0 1 a5a5 1234 0 0 1 1 18 1 13c 0 0
6 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0

/* sim.f */
logic/rvCorePkg.sv
logic/renamePkg.sv
logic/issueIf.sv
logic/commitIf.sv
logic/archRegData.sv
logic/renameTagTable.sv
logic/dispatchStage.sv
logic/regRenameTop.sv
dv/regRename_assertions.sv
dv/regRenameTb.sv

/* runSim.sh */
#!/bin/sh
# Run from the project root
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module regRenameTb \
    --Mdir obj_dir -o regRenameSim \
    && ./obj_dir/regRenameSim > sim.log 2>&1 \
    || echo "Build or simulation did not complete"
cat sim.log 2>/dev/null
grep -q "^Done: no errors$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

/* dv/regRenameTb.sv */
`timescale 1ns/100ps

module regRenameTb;
    import rvCorePkg::*;
    import renamePkg::*;

    logic                    clk;
    logic                    rst;
    logic                    rdy;
    logic                    flush;
    logic                    issueValid;
    logic [regNameWidth-1:0] issueRs1;
    logic [regNameWidth-1:0] issueRs2;
    logic [regNameWidth-1:0] issueRd;
    opcode_e                 issueOp;
    logic [addrWidth-1:0]    issuePc;
    logic [immWidth-1:0]     issueImm;
    logic                    issuePredTaken;
    logic                    assignValid;
    logic [regNameWidth-1:0] assignRd;
    logic [tagWidth-1:0]     assignTag;
    logic                    commitValid;
    logic [regNameWidth-1:0] commitRd;
    logic [dataWidth-1:0]    commitData;
    logic [tagWidth-1:0]     commitTag;

    logic                    dispatchValid;
    logic [dataWidth-1:0]    dispatchRs1Data;
    logic [dataWidth-1:0]    dispatchRs2Data;
    logic [tagWidth-1:0]     dispatchRs1Tag;
    logic [tagWidth-1:0]     dispatchRs2Tag;
    logic                    dispatchRs1Ready;
    logic                    dispatchRs2Ready;
    logic [regNameWidth-1:0] dispatchRd;
    opcode_e                 dispatchOp;
    logic [addrWidth-1:0]    dispatchPc;
    logic [immWidth-1:0]     dispatchImm;
    logic                    dispatchPredTaken;

    string       lines[$];
    logic [31:0] f [30];   // Test id, 17 inputs, 12 expected outputs
    int          errors = 0;
    int          testErrors = 0;
    int          testsRun = 0;
    int          vectorCount = 0;
    int          cycleCount = 0;
    int          cycleLimit = 0;

    regRenameTop u_regRenameTop (.*);

    always #2 clk = ~clk;

    // Run limit is set once the vector count is known
    always @(posedge clk) begin
        cycleCount++;
        if (cycleLimit != 0 && cycleCount > cycleLimit) begin
            $display("Timeout: run went past %0d cycles without finishing", cycleLimit);
            $display("Done: errors found");
            $finish;
        end
    end

    function automatic string testName(input int id);
        case (id)
            1: return "commit then read";
            2: return "assign then matching commit";
            3: return "stale commit ignored";
            4: return "store and branch skip assign";
            5: return "flush";
            6: return "stall";
            default: return "unnamed";
        endcase
    endfunction

    task automatic checkField(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
        if (exp !== act) begin
            $display("Mismatch %s expected %h actual %h", name, exp, act);
            errors++;
            testErrors++;
        end
    endtask

    task automatic finishTest(input int id);
        testsRun++;
        if (testErrors == 0) begin
            $display("Test %0d (%s): ok", id, testName(id));
        end else begin
            $display("Test %0d (%s): %0d errors", id, testName(id), testErrors);
        end
        testErrors = 0;
    endtask

    task automatic driveInputs();
        rdy            = f[1][0];
        flush          = f[2][0];
        issueValid     = f[3][0];
        issueRs1       = f[4][regNameWidth-1:0];
        issueRs2       = f[5][regNameWidth-1:0];
        issueRd        = f[6][regNameWidth-1:0];
        issueOp        = opcode_e'(f[7][5:0]);
        issuePc        = f[8];
        issueImm       = f[9];
        issuePredTaken = f[10][0];
        assignValid    = f[11][0];
        assignRd       = f[12][regNameWidth-1:0];
        assignTag      = f[13][tagWidth-1:0];
        commitValid    = f[14][0];
        commitRd       = f[15][regNameWidth-1:0];
        commitData     = f[16];
        commitTag      = f[17][tagWidth-1:0];
    endtask

    task automatic checkOutputs();
        checkField("dispatchValid", f[18], 32'(dispatchValid));
        checkField("dispatchRs1Data", f[19], dispatchRs1Data);
        checkField("dispatchRs2Data", f[20], dispatchRs2Data);
        checkField("dispatchRs1Tag", f[21], 32'(dispatchRs1Tag));
        checkField("dispatchRs2Tag", f[22], 32'(dispatchRs2Tag));
        checkField("dispatchRs1Ready", f[23], 32'(dispatchRs1Ready));
        checkField("dispatchRs2Ready", f[24], 32'(dispatchRs2Ready));
        checkField("dispatchRd", f[25], 32'(dispatchRd));
        checkField("dispatchOp", f[26], 32'(dispatchOp));
        checkField("dispatchPc", f[27], dispatchPc);
        checkField("dispatchImm", f[28], dispatchImm);
        checkField("dispatchPredTaken", f[29], 32'(dispatchPredTaken));
    endtask

    initial begin
        int    fd;
        int    n;
        int    curTest;
        string line;

        clk = 0;
        rst = 1;
        f = '{default: '0};
        driveInputs();
        // Live issue during reset that rst must keep out of dispatch
        rdy = 1'b1;
        issueValid = 1'b1;
        curTest = 0;

        fd = $fopen("dv/regRename_vectors.txt", "r");
        if (fd == 0) begin
            $display("Could not open the vector file dv/regRename_vectors.txt");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 1 && line[0] != "#") begin
                    lines.push_back(line);
                end
            end
            $fclose(fd);
        end
        cycleLimit = lines.size() + 20 + 3;

        repeat (3) @(posedge clk);
        #0.5 rst = 0;

        foreach (lines[i]) begin
            n = $sscanf(lines[i],
                "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
                f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19],
                f[20], f[21], f[22], f[23], f[24], f[25], f[26], f[27], f[28], f[29]);
            if (n != 30) begin
                $display("Vector line %0d has %0d fields instead of 30", i + 1, n);
                errors++;
            end else begin
                if (curTest != 0 && int'(f[0]) != curTest) begin
                    finishTest(curTest);
                end
                curTest = int'(f[0]);
                driveInputs();
                vectorCount++;
                @(posedge clk);
                #0.4;
                checkOutputs();
                #0.1;
            end
        end
        if (curTest != 0) begin
            finishTest(curTest);
        end

        $display("Tests: %0d, vectors: %0d, errors: %0d", testsRun, vectorCount, errors);
        if (errors == 0 && vectorCount > 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* dv/regRename_assertions.sv */
`timescale 1ns/100ps

module regRenameAssertions (
    input logic                               clk,
    input logic                               rst,
    input logic                               rdy,
    input logic                               flush,
    input logic                               dispatchValid,
    input logic [rvCorePkg::dataWidth-1:0]    dispatchRs1Data,
    input logic [rvCorePkg::dataWidth-1:0]    dispatchRs2Data,
    input logic [renamePkg::tagWidth-1:0]     dispatchRs1Tag,
    input logic [renamePkg::tagWidth-1:0]     dispatchRs2Tag,
    input logic [rvCorePkg::regNameWidth-1:0] dispatchRd,
    input logic [rvCorePkg::addrWidth-1:0]    dispatchPc
);

    resetKillsDispatch: assert property (@(posedge clk) rst |=> !dispatchValid)
        else $error("dispatchValid high after reset");

    flushKillsDispatch: assert property (@(posedge clk) flush |=> !dispatchValid)
        else $error("dispatchValid high after flush");

    // Stalled edge keeps the whole packet
    stallHoldsPacket: assert property (@(posedge clk)
        (!rdy && !flush && !rst) |=> ($stable(dispatchValid) && $stable(dispatchRs1Data) &&
            $stable(dispatchRs2Data) && $stable(dispatchRs1Tag) &&
            $stable(dispatchRs2Tag) && $stable(dispatchRd) && $stable(dispatchPc)))
        else $error("dispatch outputs changed while rdy low");

endmodule

bind regRenameTop regRenameAssertions u_regRenameAssertions (
    .clk             (clk),
    .rst             (rst),
    .rdy             (rdy),
    .flush           (flush),
    .dispatchValid   (dispatchValid),
    .dispatchRs1Data (dispatchRs1Data),
    .dispatchRs2Data (dispatchRs2Data),
    .dispatchRs1Tag  (dispatchRs1Tag),
    .dispatchRs2Tag  (dispatchRs2Tag),
    .dispatchRd      (dispatchRd),
    .dispatchPc      (dispatchPc)
);

/* logic/regRenameTop.sv */
`timescale 1ns/100ps

module regRenameTop (
    input  logic clk,
    input  logic rst,
    input  logic rdy,
    input  logic flush,

    input  logic                               issueValid,
    input  logic [rvCorePkg::regNameWidth-1:0] issueRs1,
    input  logic [rvCorePkg::regNameWidth-1:0] issueRs2,
    input  logic [rvCorePkg::regNameWidth-1:0] issueRd,
    input  rvCorePkg::opcode_e                 issueOp,
    input  logic [rvCorePkg::addrWidth-1:0]    issuePc,
    input  logic [rvCorePkg::immWidth-1:0]     issueImm,
    input  logic                               issuePredTaken,

    input  logic                               assignValid,
    input  logic [rvCorePkg::regNameWidth-1:0] assignRd,
    input  logic [renamePkg::tagWidth-1:0]     assignTag,

    input  logic                               commitValid,
    input  logic [rvCorePkg::regNameWidth-1:0] commitRd,
    input  logic [rvCorePkg::dataWidth-1:0]    commitData,
    input  logic [renamePkg::tagWidth-1:0]     commitTag,

    output logic                               dispatchValid,
    output logic [rvCorePkg::dataWidth-1:0]    dispatchRs1Data,
    output logic [rvCorePkg::dataWidth-1:0]    dispatchRs2Data,
    output logic [renamePkg::tagWidth-1:0]     dispatchRs1Tag,
    output logic [renamePkg::tagWidth-1:0]     dispatchRs2Tag,
    output logic                               dispatchRs1Ready,
    output logic                               dispatchRs2Ready,
    output logic [rvCorePkg::regNameWidth-1:0] dispatchRd,
    output rvCorePkg::opcode_e                 dispatchOp,
    output logic [rvCorePkg::addrWidth-1:0]    dispatchPc,
    output logic [rvCorePkg::immWidth-1:0]     dispatchImm,
    output logic                               dispatchPredTaken
);
    import rvCorePkg::*;
    import renamePkg::*;

    issueIf  issueBus ();
    commitIf commitBus ();

    logic [dataWidth-1:0] rs1Data;
    logic [dataWidth-1:0] rs2Data;
    logic [tagWidth-1:0]  rs1Tag;
    logic [tagWidth-1:0]  rs2Tag;

    assign issueBus.valid     = issueValid;
    assign issueBus.rs1       = issueRs1;
    assign issueBus.rs2       = issueRs2;
    assign issueBus.rd        = issueRd;
    assign issueBus.op        = issueOp;
    assign issueBus.pc        = issuePc;
    assign issueBus.imm       = issueImm;
    assign issueBus.predTaken = issuePredTaken;

    // accept comes back from the tag table
    assign commitBus.valid = commitValid;
    assign commitBus.rd    = commitRd;
    assign commitBus.data  = commitData;
    assign commitBus.tag   = commitTag;

    archRegData u_archRegData (
        .clk     (clk),
        .rst     (rst),
        .rdy     (rdy),
        .flush   (flush),
        .issue   (issueBus),
        .commit  (commitBus),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data)
    );

    renameTagTable u_renameTagTable (
        .clk         (clk),
        .rst         (rst),
        .rdy         (rdy),
        .flush       (flush),
        .issue       (issueBus),
        .commit      (commitBus),
        .assignValid (assignValid),
        .assignRd    (assignRd),
        .assignTag   (assignTag),
        .rs1Tag      (rs1Tag),
        .rs2Tag      (rs2Tag)
    );

    dispatchStage u_dispatchStage (
        .clk               (clk),
        .rst               (rst),
        .rdy               (rdy),
        .flush             (flush),
        .issue             (issueBus),
        .rs1Data           (rs1Data),
        .rs2Data           (rs2Data),
        .rs1Tag            (rs1Tag),
        .rs2Tag            (rs2Tag),
        .dispatchValid     (dispatchValid),
        .dispatchRs1Data   (dispatchRs1Data),
        .dispatchRs2Data   (dispatchRs2Data),
        .dispatchRs1Tag    (dispatchRs1Tag),
        .dispatchRs2Tag    (dispatchRs2Tag),
        .dispatchRs1Ready  (dispatchRs1Ready),
        .dispatchRs2Ready  (dispatchRs2Ready),
        .dispatchRd        (dispatchRd),
        .dispatchOp        (dispatchOp),
        .dispatchPc        (dispatchPc),
        .dispatchImm       (dispatchImm),
        .dispatchPredTaken (dispatchPredTaken)
    );

endmodule

/* logic/dispatchStage.sv */
`timescale 1ns/100ps

module dispatchStage (
    input  logic clk,
    input  logic rst,
    input  logic rdy,
    input  logic flush,

    issueIf.packet issue,

    input  logic [rvCorePkg::dataWidth-1:0] rs1Data,
    input  logic [rvCorePkg::dataWidth-1:0] rs2Data,
    input  logic [renamePkg::tagWidth-1:0]  rs1Tag,
    input  logic [renamePkg::tagWidth-1:0]  rs2Tag,

    output logic                               dispatchValid,
    output logic [rvCorePkg::dataWidth-1:0]    dispatchRs1Data,
    output logic [rvCorePkg::dataWidth-1:0]    dispatchRs2Data,
    output logic [renamePkg::tagWidth-1:0]     dispatchRs1Tag,
    output logic [renamePkg::tagWidth-1:0]     dispatchRs2Tag,
    output logic                               dispatchRs1Ready,
    output logic                               dispatchRs2Ready,
    output logic [rvCorePkg::regNameWidth-1:0] dispatchRd,
    output rvCorePkg::opcode_e                 dispatchOp,
    output logic [rvCorePkg::addrWidth-1:0]    dispatchPc,
    output logic [rvCorePkg::immWidth-1:0]     dispatchImm,
    output logic                               dispatchPredTaken
);
    import rvCorePkg::*;
    import renamePkg::*;

    logic captureEn;
    logic clearEn;

    assign captureEn = rdy && issue.valid;
    // Idle cycle, flush or reset all empty the register
    assign clearEn   = rst || flush || (rdy && !issue.valid);

    always_ff @(posedge clk) begin
        if (clearEn) begin
            dispatchValid     <= 1'b0;
            dispatchRs1Data   <= '0;
            dispatchRs2Data   <= '0;
            dispatchRs1Tag    <= tagReady;
            dispatchRs2Tag    <= tagReady;
            dispatchRs1Ready  <= 1'b0;
            dispatchRs2Ready  <= 1'b0;
            dispatchRd        <= '0;
            dispatchOp        <= NOP;
            dispatchPc        <= '0;
            dispatchImm       <= '0;
            dispatchPredTaken <= 1'b0;
        end else if (captureEn) begin
            dispatchValid     <= 1'b1;
            dispatchRs1Data   <= rs1Data;
            dispatchRs2Data   <= rs2Data;
            dispatchRs1Tag    <= rs1Tag;
            dispatchRs2Tag    <= rs2Tag;
            dispatchRs1Ready  <= rs1Tag == tagReady;
            dispatchRs2Ready  <= rs2Tag == tagReady;
            dispatchRd        <= issue.rd;
            dispatchOp        <= issue.op;
            dispatchPc        <= issue.pc;
            dispatchImm       <= issue.imm;
            dispatchPredTaken <= issue.predTaken;
        end
        // rdy low holds everything
    end

endmodule

/* logic/renameTagTable.sv */
`timescale 1ns/100ps

module renameTagTable (
    input  logic clk,
    input  logic rst,
    input  logic rdy,
    input  logic flush,

    issueIf.reader   issue,
    commitIf.tagSide commit,

    input  logic                             assignValid,
    input  logic [rvCorePkg::regNameWidth-1:0] assignRd,
    input  logic [renamePkg::tagWidth-1:0]     assignTag,

    output logic [renamePkg::tagWidth-1:0] rs1Tag,
    output logic [renamePkg::tagWidth-1:0] rs2Tag
);
    import rvCorePkg::*;
    import renamePkg::*;

    logic [tagWidth-1:0] tags [regCount];
    logic                noRdWrite;
    logic                assignEn;

    // Stores and branches have no destination to rename
    always_comb begin
        case (issue.op)
            SB, SH, SW,
            BEQ, BNE, BLT, BGE, BLTU, BGEU: noRdWrite = issue.valid;
            default:                        noRdWrite = 1'b0;
        endcase
    end

    assign assignEn = assignValid && assignRd != '0 && !noRdWrite;

    // Only the newest producer may retire the rename
    assign commit.accept = commit.valid && commit.rd != '0 &&
                           tags[commit.rd] == commit.tag;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            for (int i = 0; i < regCount; i++) begin
                tags[i] <= tagReady;
            end
        end else if (rdy) begin
            if (commit.accept) begin
                tags[commit.rd] <= tagReady;
            end
            // Later write wins when both hit one register
            if (assignEn) begin
                tags[assignRd] <= assignTag;
            end
        end
    end

    assign rs1Tag = tags[issue.rs1];
    assign rs2Tag = tags[issue.rs2];

endmodule

/* logic/archRegData.sv */
`timescale 1ns/100ps

module archRegData (
    input  logic clk,
    input  logic rst,
    input  logic rdy,
    input  logic flush,

    issueIf.reader   issue,
    commitIf.dataSide commit,

    output logic [rvCorePkg::dataWidth-1:0] rs1Data,
    output logic [rvCorePkg::dataWidth-1:0] rs2Data
);
    import rvCorePkg::*;

    logic [dataWidth-1:0] regs [regCount];
    logic                 writeEn;

    // A flush commit lands whatever its tag, otherwise the tag table decides
    always_comb begin
        writeEn = 1'b0;
        if (commit.valid && commit.rd != '0) begin
            if (flush) begin
                writeEn = 1'b1;
            end else if (rdy && commit.accept) begin
                writeEn = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn) begin
            regs[commit.rd] <= commit.data;
        end
    end

    // Reads see the array before this cycle's commit
    always_comb begin
        if (issue.rs1 == '0) begin
            rs1Data = '0;
        end else begin
            rs1Data = regs[issue.rs1];
        end
        if (issue.rs2 == '0) begin
            rs2Data = '0;
        end else begin
            rs2Data = regs[issue.rs2];
        end
    end

endmodule

/* logic/commitIf.sv */
`timescale 1ns/100ps

interface commitIf;
    import rvCorePkg::*;
    import renamePkg::*;

    logic                    valid;
    logic [regNameWidth-1:0] rd;
    logic [dataWidth-1:0]    data;
    logic [tagWidth-1:0]     tag;
    logic                    accept;   // Tag still matches, commit may land

    modport tagSide (
        input  valid, rd, tag,
        output accept
    );

    modport dataSide (
        input valid, rd, data, accept
    );

endinterface

/* logic/issueIf.sv */
`timescale 1ns/100ps

interface issueIf;
    import rvCorePkg::*;

    logic                    valid;
    logic [regNameWidth-1:0] rs1;
    logic [regNameWidth-1:0] rs2;
    logic [regNameWidth-1:0] rd;
    opcode_e                 op;
    logic [addrWidth-1:0]    pc;
    logic [immWidth-1:0]     imm;
    logic                    predTaken;

    modport source (
        output valid, rs1, rs2, rd, op, pc, imm, predTaken
    );

    // Side reads, op lets the tag table spot stores and branches
    modport reader (
        input valid, rs1, rs2, op
    );

    modport packet (
        input valid, rs1, rs2, rd, op, pc, imm, predTaken
    );

endinterface

/* logic/renamePkg.sv */
package renamePkg;

    // Reorder buffer size, entry 0 never handed out
    localparam int tagCount = 16;
    localparam int tagWidth = $clog2(tagCount);

    // Register holds its committed value
    localparam logic [tagWidth-1:0] tagReady = '0;

endpackage

/* logic/rvCorePkg.sv */
package rvCorePkg;

    localparam int dataWidth    = 32;
    localparam int regCount     = 32;
    localparam int regNameWidth = $clog2(regCount);
    localparam int addrWidth    = 32;
    localparam int immWidth     = 32;

    // Internal operation codes, numbered in order from NOP = 0
    typedef enum logic [5:0] {
        NOP,
        // ALU register and immediate forms
        ADD, SUB, SLL, SLT, SLTU,
        XOR, SRL, SRA, OR, AND,
        ADDI, SLTI, SLTIU, XORI, ORI,
        ANDI, SLLI, SRLI, SRAI,
        // Loads
        LB, LH, LW, LBU, LHU,
        // Stores
        SB, SH, SW,
        // Branches
        BEQ, BNE, BLT, BGE, BLTU, BGEU,
        // Jumps
        JAL, JALR,
        // Upper immediates
        LUI, AUIPC
    } opcode_e;

endpackage
